/* axil_recorder.f */
+incdir+design
design/axil_rr_pkg.sv
design/axil_channel_logger.sv
design/axil_log_packer.sv
design/axil_recorder.sv
tests/tb_axil_recorder.sv

/* design/axil_channel_logger.sv */
module axil_channel_logger #(
   parameter int PAYLOAD_W = 32
) (
   input  logic                 i_clk,
   input  logic                 i_reset,
   input  logic                 i_stall,
   // Upstream side
   input  logic                 i_valid,
   output logic                 o_ready,
   input  logic [PAYLOAD_W-1:0] i_data,
   // Downstream side
   output logic                 o_valid,
   input  logic                 i_ready,
   output logic [PAYLOAD_W-1:0] o_data,
   // Log events
   output logic                 o_begin,
   output logic                 o_end
);

   typedef enum logic {
      STAGE_EMPTY,
      STAGE_FULL
   } stage_e;

   stage_e               state;
   logic                 live;
   logic                 can_take;
   logic [PAYLOAD_W-1:0] data_q;

   // Keeps the input ready low through reset and the cycle after it
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         live <= 1'b0;
      end else begin
         live <= 1'b1;
      end
   end

   // Output side hidden while stalled
   assign o_valid = (state == STAGE_FULL) && !i_stall;
   assign o_end   = o_valid && i_ready;
   assign o_data  = data_q;

   // Stage can refill in the same cycle its beat leaves
   assign can_take = (state == STAGE_EMPTY) || o_end;
   assign o_ready  = live && !i_stall && can_take;
   assign o_begin  = i_valid && o_ready;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state <= STAGE_EMPTY;
      end else if (o_begin) begin
         state <= STAGE_FULL;
      end else if (o_end) begin
         state <= STAGE_EMPTY;
      end
   end

   always_ff @(posedge i_clk) begin
      if (o_begin) begin
         data_q <= i_data;
      end
   end

   // Beat waiting on the far side must not change under it
   assert property (@(posedge i_clk) disable iff (i_reset)
      (o_valid && !i_ready) |=> (o_data == $past(o_data)))
      else $error("FAILED: logger payload changed while waiting for ready");

endmodule

/* design/axil_log_packer.sv */
`include "axil_rr_macros.svh"

module axil_log_packer #(
   parameter type REC_T     = axil_rr_pkg::m2s_log_t,
   parameter int  NUM_BEGIN = 3
) (
   input  logic                                i_clk,
   input  logic                                i_reset,
   // Events from the channel loggers
   input  logic [NUM_BEGIN-1:0]                i_begin,
   input  logic [$bits(REC_T)-NUM_BEGIN-axil_rr_pkg::LOGE_CNT-1:0] i_begin_data,
   input  logic [axil_rr_pkg::LOGE_CNT-1:0]    i_end,
   // Log stream
   output logic                                o_rec_valid,
   output REC_T                                o_rec,
   input  logic                                i_credit,
   output logic                                o_no_credit
);

   localparam logic [`RR_CREDIT_W-1:0] CREDIT_MAX = `RR_LOG_CREDITS;

   logic [`RR_CREDIT_W-1:0] credits;
   logic                    any_event;
   logic                    rec_valid_q;
   REC_T                    rec_q;

   assign any_event = (|i_begin) || (|i_end);

   // Spent when a record is captured, so the stall lands before the next one
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         credits <= CREDIT_MAX;
      end else begin
         case ({any_event, i_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   assign o_no_credit = (credits == '0);

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rec_valid_q <= 1'b0;
      end else begin
         rec_valid_q <= any_event;
      end
   end

   // Field order of REC_T is begin bits, payloads, end vector
   always_ff @(posedge i_clk) begin
      if (any_event) begin
         rec_q <= REC_T'({i_begin, i_begin_data, i_end});
      end
   end

   assign o_rec_valid = rec_valid_q;
   assign o_rec       = rec_q;

   // Sink returned more than it was given
   assert property (@(posedge i_clk) disable iff (i_reset)
      credits <= CREDIT_MAX)
      else $error("FAILED: log credit count above %0d", `RR_LOG_CREDITS);

   // Record went out without a credit behind it
   assert property (@(posedge i_clk) disable iff (i_reset)
      o_rec_valid |-> ($past(credits) != '0))
      else $error("FAILED: log record sent with no credit");

endmodule

/* design/axil_recorder.sv */
module axil_recorder (
   input  logic                   i_clk,
   input  logic                   i_reset,
   // Master side
   input  axil_rr_pkg::axil_m2s_t i_m,
   output axil_rr_pkg::axil_s2m_t o_m,
   // Slave side
   output axil_rr_pkg::axil_m2s_t o_s,
   input  axil_rr_pkg::axil_s2m_t i_s,
   // Log streams
   output logic                   o_m2s_log_valid,
   output axil_rr_pkg::m2s_log_t  o_m2s_log,
   output logic                   o_s2m_log_valid,
   output axil_rr_pkg::s2m_log_t  o_s2m_log,
   input  logic                   i_m2s_credit,
   input  logic                   i_s2m_credit
);

   logic                             stall;
   logic                             m2s_no_credit;
   logic                             s2m_no_credit;
   logic [axil_rr_pkg::LOGE_CNT-1:0] loge;
   logic                             aw_begin;
   logic                             w_begin;
   logic                             ar_begin;
   logic                             b_begin;
   logic                             r_begin;

   // Either stream out of credits holds every channel
   assign stall = m2s_no_credit || s2m_no_credit;

   // AW, master to slave
   axil_channel_logger #(
      .PAYLOAD_W($bits(axil_rr_pkg::axil_aw_t))
   ) aw_logger (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_stall (stall),
      .i_valid (i_m.awvalid),
      .o_ready (o_m.awready),
      .i_data  (i_m.aw),
      .o_valid (o_s.awvalid),
      .i_ready (i_s.awready),
      .o_data  (o_s.aw),
      .o_begin (aw_begin),
      .o_end   (loge[axil_rr_pkg::LOGE_AW])
   );

   // W, master to slave
   axil_channel_logger #(
      .PAYLOAD_W($bits(axil_rr_pkg::axil_w_t))
   ) w_logger (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_stall (stall),
      .i_valid (i_m.wvalid),
      .o_ready (o_m.wready),
      .i_data  (i_m.w),
      .o_valid (o_s.wvalid),
      .i_ready (i_s.wready),
      .o_data  (o_s.w),
      .o_begin (w_begin),
      .o_end   (loge[axil_rr_pkg::LOGE_W])
   );

   // AR, master to slave
   axil_channel_logger #(
      .PAYLOAD_W($bits(axil_rr_pkg::axil_ar_t))
   ) ar_logger (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_stall (stall),
      .i_valid (i_m.arvalid),
      .o_ready (o_m.arready),
      .i_data  (i_m.ar),
      .o_valid (o_s.arvalid),
      .i_ready (i_s.arready),
      .o_data  (o_s.ar),
      .o_begin (ar_begin),
      .o_end   (loge[axil_rr_pkg::LOGE_AR])
   );

   // B, slave to master
   axil_channel_logger #(
      .PAYLOAD_W($bits(axil_rr_pkg::axil_b_t))
   ) b_logger (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_stall (stall),
      .i_valid (i_s.bvalid),
      .o_ready (o_s.bready),
      .i_data  (i_s.b),
      .o_valid (o_m.bvalid),
      .i_ready (i_m.bready),
      .o_data  (o_m.b),
      .o_begin (b_begin),
      .o_end   (loge[axil_rr_pkg::LOGE_B])
   );

   // R, slave to master
   axil_channel_logger #(
      .PAYLOAD_W($bits(axil_rr_pkg::axil_r_t))
   ) r_logger (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_stall (stall),
      .i_valid (i_s.rvalid),
      .o_ready (o_s.rready),
      .i_data  (i_s.r),
      .o_valid (o_m.rvalid),
      .i_ready (i_m.rready),
      .o_data  (o_m.r),
      .o_begin (r_begin),
      .o_end   (loge[axil_rr_pkg::LOGE_R])
   );

   // Both streams see the full end vector
   axil_log_packer #(
      .REC_T     (axil_rr_pkg::m2s_log_t),
      .NUM_BEGIN (3)
   ) m2s_packer (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_begin      ({aw_begin, w_begin, ar_begin}),
      .i_begin_data ({i_m.aw, i_m.w, i_m.ar}),
      .i_end        (loge),
      .o_rec_valid  (o_m2s_log_valid),
      .o_rec        (o_m2s_log),
      .i_credit     (i_m2s_credit),
      .o_no_credit  (m2s_no_credit)
   );

   axil_log_packer #(
      .REC_T     (axil_rr_pkg::s2m_log_t),
      .NUM_BEGIN (2)
   ) s2m_packer (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_begin      ({b_begin, r_begin}),
      .i_begin_data ({i_s.b, i_s.r}),
      .i_end        (loge),
      .o_rec_valid  (o_s2m_log_valid),
      .o_rec        (o_s2m_log),
      .i_credit     (i_s2m_credit),
      .o_no_credit  (s2m_no_credit)
   );

endmodule

/* design/axil_rr_macros.svh */
`ifndef AXIL_RR_MACROS_SVH
`define AXIL_RR_MACROS_SVH

// AXI-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4
`define AXIL_RESP_W 2

// Log stream flow control
// Records the sink can absorb right after reset
`define RR_LOG_CREDITS 4

// Wide enough to hold RR_LOG_CREDITS plus one, so an overrun is visible
`define RR_CREDIT_W 3

`endif

/* design/axil_rr_pkg.sv */
`include "axil_rr_macros.svh"

package axil_rr_pkg;

   // Channel payloads
   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
   } axil_aw_t;

   typedef struct packed {
      logic [`AXIL_DATA_W-1:0] data;
      logic [`AXIL_STRB_W-1:0] strb;
   } axil_w_t;

   typedef struct packed {
      logic [`AXIL_ADDR_W-1:0] addr;
   } axil_ar_t;

   typedef struct packed {
      logic [`AXIL_RESP_W-1:0] resp;
   } axil_b_t;

   typedef struct packed {
      logic [`AXIL_DATA_W-1:0] data;
      logic [`AXIL_RESP_W-1:0] resp;
   } axil_r_t;

   // Bit positions in the end-event vector
   typedef enum logic [2:0] {
      LOGE_AW = 3'd0,
      LOGE_W  = 3'd1,
      LOGE_AR = 3'd2,
      LOGE_B  = 3'd3,
      LOGE_R  = 3'd4
   } loge_id_e;

   localparam int LOGE_CNT = int'(LOGE_R) + 1;

   // Begin bits first, then payloads, then end vector
   typedef struct packed {
      logic                aw_begin;
      logic                w_begin;
      logic                ar_begin;
      axil_aw_t            aw;
      axil_w_t             w;
      axil_ar_t            ar;
      logic [LOGE_CNT-1:0] loge;
   } m2s_log_t;

   typedef struct packed {
      logic                b_begin;
      logic                r_begin;
      axil_b_t             b;
      axil_r_t             r;
      logic [LOGE_CNT-1:0] loge;
   } s2m_log_t;

   // Driven by the master
   typedef struct packed {
      logic     awvalid;
      axil_aw_t aw;
      logic     wvalid;
      axil_w_t  w;
      logic     arvalid;
      axil_ar_t ar;
      logic     bready;
      logic     rready;
   } axil_m2s_t;

   // Driven by the slave
   typedef struct packed {
      logic    awready;
      logic    wready;
      logic    arready;
      logic    bvalid;
      axil_b_t b;
      logic    rvalid;
      axil_r_t r;
   } axil_s2m_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
   --top-module tb_axil_recorder \
   -f axil_recorder.f \
   -o tb_axil_recorder > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_axil_recorder > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "CHECKS FAILED" "$SIM_LOG"; then
   exit 1
fi
exit 0

/* tests/tb_axil_recorder.sv */
`include "axil_rr_macros.svh"

module tb_axil_recorder;

   localparam int NBEATS         = 40;
   // About fifty cycles per beat of one channel
   localparam int TIMEOUT_CYCLES = NBEATS * 50;
   localparam int HOLD_START     = 60;
   localparam int HOLD_LEN       = 30;
   localparam int CREDITS        = `RR_LOG_CREDITS;
   localparam int AW             = int'(axil_rr_pkg::LOGE_AW);
   localparam int W              = int'(axil_rr_pkg::LOGE_W);
   localparam int AR             = int'(axil_rr_pkg::LOGE_AR);
   localparam int B              = int'(axil_rr_pkg::LOGE_B);
   localparam int R              = int'(axil_rr_pkg::LOGE_R);

   logic                   i_clk;
   logic                   i_reset;
   axil_rr_pkg::axil_m2s_t i_m;
   axil_rr_pkg::axil_s2m_t o_m;
   axil_rr_pkg::axil_m2s_t o_s;
   axil_rr_pkg::axil_s2m_t i_s;
   logic                   o_m2s_log_valid;
   axil_rr_pkg::m2s_log_t  o_m2s_log;
   logic                   o_s2m_log_valid;
   axil_rr_pkg::s2m_log_t  o_s2m_log;
   logic                   i_m2s_credit;
   logic                   i_s2m_credit;

   // Beats each side sends, in order
   axil_rr_pkg::axil_aw_t aw_pay [NBEATS];
   axil_rr_pkg::axil_w_t  w_pay  [NBEATS];
   axil_rr_pkg::axil_ar_t ar_pay [NBEATS];
   axil_rr_pkg::axil_b_t  b_pay  [NBEATS];
   axil_rr_pkg::axil_r_t  r_pay  [NBEATS];

   int                    in_cnt [5];
   int                    out_cnt [5];
   int                    shown [5];
   int                    cycle;
   int                    stall_cycles;
   int                    value_errs;
   int                    other_errs;
   int                    m2s_avail_q;
   int                    s2m_avail_q;
   int                    m2s_avail_now;
   int                    s2m_avail_now;
   logic                  rst_q;
   logic                  holding;
   logic                  all_done;
   logic                  quiet;
   logic [4:0]            hs_in;
   logic [4:0]            hs_out;
   logic                  m2s_exp_valid;
   logic                  s2m_exp_valid;
   axil_rr_pkg::m2s_log_t m2s_exp;
   axil_rr_pkg::m2s_log_t m2s_seen;
   axil_rr_pkg::s2m_log_t s2m_exp;
   axil_rr_pkg::s2m_log_t s2m_seen;
   axil_rr_pkg::axil_aw_t exp_aw;
   axil_rr_pkg::axil_w_t  exp_w;
   axil_rr_pkg::axil_ar_t exp_ar;
   axil_rr_pkg::axil_b_t  exp_b;
   axil_rr_pkg::axil_r_t  exp_r;

   axil_recorder dut0 (.*);

   initial i_clk = 1'b0;
   always #10 i_clk = ~i_clk;

   assign hs_in  = {i_s.rvalid && o_s.rready, i_s.bvalid && o_s.bready,
                    i_m.arvalid && o_m.arready, i_m.wvalid && o_m.wready,
                    i_m.awvalid && o_m.awready};
   assign hs_out = {o_m.rvalid && i_m.rready, o_m.bvalid && i_m.bready,
                    o_s.arvalid && i_s.arready, o_s.wvalid && i_s.wready,
                    o_s.awvalid && i_s.awready};

   // Credits the recorder holds in the current cycle
   assign m2s_avail_now = m2s_avail_q - (o_m2s_log_valid ? 1 : 0);
   assign s2m_avail_now = s2m_avail_q - (o_s2m_log_valid ? 1 : 0);

   assign holding  = (cycle >= HOLD_START) && (cycle < HOLD_START + HOLD_LEN);
   assign all_done = (out_cnt[AW] == NBEATS) && (out_cnt[W] == NBEATS)
                     && (out_cnt[AR] == NBEATS) && (out_cnt[B] == NBEATS)
                     && (out_cnt[R] == NBEATS);
   assign quiet    = !(o_m.awready || o_m.wready || o_m.arready || o_s.bready || o_s.rready
                       || o_s.awvalid || o_s.wvalid || o_s.arvalid || o_m.bvalid
                       || o_m.rvalid || o_m2s_log_valid || o_s2m_log_valid);

   always_comb begin
      exp_aw   = aw_pay[out_cnt[AW] % NBEATS];
      exp_w    = w_pay[out_cnt[W] % NBEATS];
      exp_ar   = ar_pay[out_cnt[AR] % NBEATS];
      exp_b    = b_pay[out_cnt[B] % NBEATS];
      exp_r    = r_pay[out_cnt[R] % NBEATS];
      // Payload fields only count where the begin bit is set
      m2s_seen = o_m2s_log;
      s2m_seen = o_s2m_log;
      if (!o_m2s_log.aw_begin) m2s_seen.aw = '0;
      if (!o_m2s_log.w_begin) m2s_seen.w = '0;
      if (!o_m2s_log.ar_begin) m2s_seen.ar = '0;
      if (!o_s2m_log.b_begin) s2m_seen.b = '0;
      if (!o_s2m_log.r_begin) s2m_seen.r = '0;
   end

   function automatic logic coin();
      return ($urandom_range(3) != 0);
   endfunction

   function automatic logic want_beat(input int ch, input int limit);
      return (in_cnt[ch] < limit) && coin();
   endfunction

   task automatic report_value(input string name, input string got, input string exp);
      value_errs++;
      $display("FAILED at %0t: %s = %s, expected %s", $time, name, got, exp);
   endtask

   task automatic fault(input string what);
      other_errs++;
      $display("Error at %0t: %s", $time, what);
   endtask

   task automatic print_totals();
      $display("Totals: %0d value errors, %0d other errors", value_errs, other_errs);
   endtask

   // Master, slave and credit sink
   always @(negedge i_clk) begin
      if (!rst_q) begin
         if (!(i_m.awvalid && in_cnt[AW] == shown[AW])) begin
            i_m.awvalid = want_beat(AW, NBEATS);
            i_m.aw      = aw_pay[in_cnt[AW] % NBEATS];
            shown[AW]   = in_cnt[AW];
         end
         if (!(i_m.wvalid && in_cnt[W] == shown[W])) begin
            i_m.wvalid = want_beat(W, NBEATS);
            i_m.w      = w_pay[in_cnt[W] % NBEATS];
            shown[W]   = in_cnt[W];
         end
         if (!(i_m.arvalid && in_cnt[AR] == shown[AR])) begin
            i_m.arvalid = want_beat(AR, NBEATS);
            i_m.ar      = ar_pay[in_cnt[AR] % NBEATS];
            shown[AR]   = in_cnt[AR];
         end
         // A response waits for both halves of its write
         if (!(i_s.bvalid && in_cnt[B] == shown[B])) begin
            i_s.bvalid = want_beat(B, (out_cnt[AW] < out_cnt[W]) ? out_cnt[AW] : out_cnt[W]);
            i_s.b      = b_pay[in_cnt[B] % NBEATS];
            shown[B]   = in_cnt[B];
         end
         if (!(i_s.rvalid && in_cnt[R] == shown[R])) begin
            i_s.rvalid = want_beat(R, out_cnt[AR]);
            i_s.r      = r_pay[in_cnt[R] % NBEATS];
            shown[R]   = in_cnt[R];
         end
         i_s.awready  = coin();
         i_s.wready   = coin();
         i_s.arready  = coin();
         i_m.bready   = coin();
         i_m.rready   = coin();
         i_m2s_credit = !holding && (m2s_avail_q < CREDITS) && ($urandom_range(1) == 1);
         i_s2m_credit = !holding && (s2m_avail_q < CREDITS) && ($urandom_range(1) == 1);
      end
   end

   // Scoreboard state
   always @(posedge i_clk) begin
      rst_q <= i_reset;
      if (i_reset) begin
         m2s_avail_q   <= CREDITS;
         s2m_avail_q   <= CREDITS;
         m2s_exp_valid <= 1'b0;
         s2m_exp_valid <= 1'b0;
      end else begin
         for (int c = 0; c < 5; c++) begin
            if (hs_in[c]) in_cnt[c] <= in_cnt[c] + 1;
            if (hs_out[c]) out_cnt[c] <= out_cnt[c] + 1;
         end
         m2s_exp_valid    <= (|hs_in[AR:AW]) || (|hs_out);
         m2s_exp.aw_begin <= hs_in[AW];
         m2s_exp.w_begin  <= hs_in[W];
         m2s_exp.ar_begin <= hs_in[AR];
         m2s_exp.aw       <= hs_in[AW] ? i_m.aw : '0;
         m2s_exp.w        <= hs_in[W] ? i_m.w : '0;
         m2s_exp.ar       <= hs_in[AR] ? i_m.ar : '0;
         m2s_exp.loge     <= hs_out;
         s2m_exp_valid    <= (|hs_in[R:B]) || (|hs_out);
         s2m_exp.b_begin  <= hs_in[B];
         s2m_exp.r_begin  <= hs_in[R];
         s2m_exp.b        <= hs_in[B] ? i_s.b : '0;
         s2m_exp.r        <= hs_in[R] ? i_s.r : '0;
         s2m_exp.loge     <= hs_out;
         m2s_avail_q      <= m2s_avail_now + (i_m2s_credit ? 1 : 0);
         s2m_avail_q      <= s2m_avail_now + (i_s2m_credit ? 1 : 0);
         if (m2s_avail_now == 0 || s2m_avail_now == 0) stall_cycles <= stall_cycles + 1;
         cycle <= cycle + 1;
      end
   end

   // Pass-through order on each channel
   assert property (@(posedge i_clk) disable iff (i_reset) hs_out[AW] |-> o_s.aw == exp_aw)
      else report_value("o_s.aw", $sformatf("%h", $sampled(o_s.aw)),
                        $sformatf("%h", $sampled(exp_aw)));
   assert property (@(posedge i_clk) disable iff (i_reset) hs_out[W] |-> o_s.w == exp_w)
      else report_value("o_s.w", $sformatf("%h", $sampled(o_s.w)),
                        $sformatf("%h", $sampled(exp_w)));
   assert property (@(posedge i_clk) disable iff (i_reset) hs_out[AR] |-> o_s.ar == exp_ar)
      else report_value("o_s.ar", $sformatf("%h", $sampled(o_s.ar)),
                        $sformatf("%h", $sampled(exp_ar)));
   assert property (@(posedge i_clk) disable iff (i_reset) hs_out[B] |-> o_m.b == exp_b)
      else report_value("o_m.b", $sformatf("%h", $sampled(o_m.b)),
                        $sformatf("%h", $sampled(exp_b)));
   assert property (@(posedge i_clk) disable iff (i_reset) hs_out[R] |-> o_m.r == exp_r)
      else report_value("o_m.r", $sformatf("%h", $sampled(o_m.r)),
                        $sformatf("%h", $sampled(exp_r)));

   // Records one cycle after their events
   assert property (@(posedge i_clk) disable iff (i_reset) o_m2s_log_valid == m2s_exp_valid)
      else report_value("o_m2s_log_valid", $sformatf("%b", $sampled(o_m2s_log_valid)),
                        $sformatf("%b", $sampled(m2s_exp_valid)));
   assert property (@(posedge i_clk) disable iff (i_reset) o_s2m_log_valid == s2m_exp_valid)
      else report_value("o_s2m_log_valid", $sformatf("%b", $sampled(o_s2m_log_valid)),
                        $sformatf("%b", $sampled(s2m_exp_valid)));
   assert property (@(posedge i_clk) disable iff (i_reset)
      o_m2s_log_valid |-> m2s_seen == m2s_exp)
      else report_value("o_m2s_log", $sformatf("%h", $sampled(m2s_seen)),
                        $sformatf("%h", $sampled(m2s_exp)));
   assert property (@(posedge i_clk) disable iff (i_reset)
      o_s2m_log_valid |-> s2m_seen == s2m_exp)
      else report_value("o_s2m_log", $sformatf("%h", $sampled(s2m_seen)),
                        $sformatf("%h", $sampled(s2m_exp)));

   // Credit flow
   assert property (@(posedge i_clk) disable iff (i_reset)
      m2s_avail_now >= 0 && s2m_avail_now >= 0)
      else fault("log record sent with no credit left");
   assert property (@(posedge i_clk) disable iff (i_reset)
      (m2s_avail_now == 0 || s2m_avail_now == 0) |-> (hs_in == '0 && hs_out == '0))
      else report_value("handshakes while out of credits",
                        $sformatf("%b/%b", $sampled(hs_in), $sampled(hs_out)), "00000/00000");

   assert property (@(posedge i_clk) rst_q |-> quiet)
      else fault("valid, ready or log valid high during reset or the cycle after it");

   initial begin
      void'($urandom(51));
      i_reset      = 1'b1;
      i_m          = '0;
      i_s          = '0;
      i_m2s_credit = 1'b0;
      i_s2m_credit = 1'b0;
      for (int k = 0; k < NBEATS; k++) begin
         aw_pay[k] = $urandom();
         w_pay[k]  = {$urandom(), 4'($urandom_range(15))};
         ar_pay[k] = $urandom();
         b_pay[k]  = 2'($urandom_range(3));
         r_pay[k]  = {$urandom(), 2'($urandom_range(3))};
      end
      repeat (5) @(posedge i_clk);
      @(negedge i_clk);
      i_reset = 1'b0;
      wait (all_done);
      // Let the last records arrive
      repeat (2) @(negedge i_clk);
      if (stall_cycles == 0) fault("credit stall was never reached");
      print_totals();
      if (value_errs == 0 && other_errs == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin
      wait (cycle == TIMEOUT_CYCLES);
      fault($sformatf("timeout, traffic not done after %0d cycles", TIMEOUT_CYCLES));
      print_totals();
      $display("CHECKS FAILED");
      $finish;
   end

endmodule
